// ==== heartMonitor.f ====
common/heartPkg.sv
verilog/spiSampler.sv
verilog/sampleTimer.sv
filter/firFilter.sv
peak/peakDetector.sv
verilog/rateControl.sv
display/rateDisplay.sv
verilog/heartMonitor.sv
sim/heartMonitorChecker.sv
sim/heartMonitorTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = heartMonitorTb
FILELIST   = heartMonitor.f
BUILD_DIR  = obj_dir
PASS_TEXT  = Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/heartMonitorTb.sv ====
// testbench with one triangle pulse test per table row, DUT is reset before each row
// short window and refresh counts keep the run small; noise comes from an xorshift
`default_nettype none

module heartMonitorTb;
	timeunit 1ns;
	timeprecision 100ps;
	import heartPkg::*;

	localparam int WindowSamples = 400;
	localparam int RefreshCycles = 8;
	localparam int ClockPeriod = 4;
	// frames allowed for arming, and frames sent after the last report
	localparam int ArmSamples = 1200;
	localparam int TailFrames = 4;
	localparam longint MarginNs = 10000;
	localparam logic [31:0] Seed = 32'h46bc_045d;

	// name, period in samples, amplitude, noise, windows, peaks per window
	localparam int Rows = 4;
	localparam logic [63:0] rowName [Rows] = '{"slowRate", "fastRate", "noisyRun", "flatLine"};
	localparam int rowPeriod [Rows] = '{200, 134, 200, 200};
	localparam int rowAmplitude [Rows] = '{400, 400, 400, 0};
	localparam bit rowNoise [Rows] = '{1'b0, 1'b0, 1'b1, 1'b0};
	localparam int rowWindows [Rows] = '{2, 3, 2, 2};
	localparam int rowPeaks [Rows] = '{2, 3, 2, 0};

	logic        sck = 1'b0;
	logic        reset;
	logic        sdo;
	logic        peakLed;
	logic        rateLed;
	logic [2:0]  digitSelect;
	segmentsT    segments;
	logic        rowDone;
	logic [63:0] testName;
	int          expectedPeaks;
	int          wantedWindows;
	int          errorCount;
	int          checkCount;
	int          reportCount;
	logic [31:0] rngState;

	always #(ClockPeriod / 2) sck = ~sck;

	heartMonitor #(.WindowSamples(WindowSamples), .RefreshCycles(RefreshCycles)) u_dut (
		.sck(sck), .reset(reset), .sdo(sdo), .peakLed(peakLed), .rateLed(rateLed),
		.digitSelect(digitSelect), .segments(segments)
	);

	heartMonitorChecker #(.RefreshCycles(RefreshCycles)) u_check (
		.sck(sck), .reset(reset), .peakLed(peakLed), .rateLed(rateLed),
		.digitSelect(digitSelect), .segments(segments), .testName(testName),
		.expectedPeaks(expectedPeaks), .windows(wantedWindows), .rowDone(rowDone),
		.errorCount(errorCount), .checkCount(checkCount), .reportCount(reportCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// rises from zero to amplitude over half a period, then falls back
	function automatic int triangle(input int period, input int amplitude, input int n);
		int half;
		int phase;
		half = period / 2;
		phase = n % period;
		if (phase < half)
			return amplitude * phase / half;
		return amplitude * (period - phase) / half;
	endfunction

	function automatic logic [15:0] nextSample(input int row, input int n);
		int value;
		value = triangle(rowPeriod[row], rowAmplitude[row], n);
		if (rowNoise[row])
		begin
			rngState = xorshift(rngState);
			value = value + int'(rngState % 32'd3) - 1;
		end
		if (value < 0)
			value = 0;
		if (value > 1023)
			value = 1023;
		// upper frame bits are junk that the sampler drops
		return {6'b10_1010, sampleT'(value)};
	endfunction

	function automatic longint timeBudget();
		longint total;
		total = MarginNs;
		for (int r = 0; r < Rows; r++)
			total += longint'(rowWindows[r] * WindowSamples + ArmSamples + TailFrames) *
				FrameBits * ClockPeriod;
		return total;
	endfunction

	// called on a rising edge, MSB first, one bit per cycle
	task automatic sendFrame(input logic [15:0] frame);
		for (int b = FrameBits - 1; b >= 0; b--)
		begin
			sdo <= frame[b];
			@(posedge sck);
		end
	endtask

	// first frame bit goes out on the edge that releases reset
	task automatic applyReset();
		reset <= 1'b1;
		sdo <= 1'b0;
		repeat (2) @(posedge sck);
		reset <= 1'b0;
	endtask

	initial
	begin : stimulus
		int frames;
		int limit;
		reset = 1'b1;
		sdo = 1'b0;
		rowDone = 1'b0;
		testName = rowName[0];
		expectedPeaks = 0;
		wantedWindows = 0;
		rngState = Seed;
		@(posedge sck);
		for (int r = 0; r < Rows; r++)
		begin
			testName <= rowName[r];
			expectedPeaks <= rowPeaks[r];
			wantedWindows <= rowWindows[r];
			applyReset();
			frames = 0;
			limit = rowWindows[r] * WindowSamples + ArmSamples;
			// stream until the wanted reports arrive, flat rows run to the limit
			while ((reportCount < rowWindows[r]) && (frames < limit))
			begin
				sendFrame(nextSample(r, frames));
				frames++;
			end
			// lets the display scan the last rate
			repeat (TailFrames)
			begin
				sendFrame(nextSample(r, frames));
				frames++;
			end
			rowDone <= 1'b1;
			@(posedge sck);
			rowDone <= 1'b0;
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin : watchdog
		longint budget;
		budget = timeBudget();
		#(budget);
		$display("run timed out after %0d ns", budget);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/heartMonitorChecker.sv ====
// samples the DUT outputs on the falling edge of sck and counts checks and errors
// expects a reset before every test row, digits scan ones, tens, hundreds
`default_nettype none

module heartMonitorChecker #(
	parameter int RefreshCycles = 8
) (
	input  logic               sck,
	input  logic               reset,
	input  logic               peakLed,
	input  logic               rateLed,
	input  logic [2:0]         digitSelect,
	input  heartPkg::segmentsT segments,
	input  logic [63:0]        testName,
	input  int                 expectedPeaks,
	input  int                 windows,
	input  logic               rowDone,
	output int                 errorCount,
	output int                 checkCount,
	output int                 reportCount
);
	timeunit 1ns;
	timeprecision 100ps;
	import heartPkg::*;

	logic       prevPeakLed;
	logic       prevRateLed;
	logic [2:0] prevSelect;
	// peakLed rises since reset, the first ArmPeaks of them only arm
	int riseCount;
	int windowPeaks;
	int lastRate;
	int sinceRise;
	// cycles left until every digit of a new rate has been shown
	int scanLeft;
	int shownDigits [3];

	// lit segments g down to a; nine with or without its tail
	function automatic int decodeSegments(input segmentsT segs);
		case (~segs)
			7'b011_1111: return 0;
			7'b000_0110: return 1;
			7'b101_1011: return 2;
			7'b100_1111: return 3;
			7'b110_0110: return 4;
			7'b110_1101: return 5;
			7'b111_1101: return 6;
			7'b000_0111: return 7;
			7'b111_1111: return 8;
			7'b110_1111, 7'b110_0111: return 9;
			default: return -1;
		endcase
	endfunction

	// active-low select to digit position, 0 is ones
	function automatic int digitPosition(input logic [2:0] sel);
		case (sel)
			3'b110: return 0;
			3'b101: return 1;
			3'b011: return 2;
			default: return -1;
		endcase
	endfunction

	function automatic int decimalDigit(input int value, input int position);
		if (position == 0)
			return value % 10;
		if (position == 1)
			return (value / 10) % 10;
		return value / 100;
	endfunction

	always @(negedge sck)
	begin : sampleOutputs
		int position;
		int shown;
		int wanted;
		if (reset)
		begin
			checkCount++;
			if (peakLed || rateLed || (digitSelect != 3'b110))
			begin
				errorCount++;
				$display("%s: LEDs or digit select are not in their reset state", testName);
			end
			prevPeakLed = 1'b0;
			prevRateLed = 1'b0;
			prevSelect = 3'b110;
			riseCount = 0;
			windowPeaks = 0;
			lastRate = 0;
			sinceRise = 0;
			scanLeft = 0;
			reportCount = 0;
			shownDigits = '{0, 0, 0};
		end
		else
		begin
			sinceRise++;
			position = digitPosition(digitSelect);
			shown = decodeSegments(segments);
			if ((position < 0) || (shown < 0))
			begin
				errorCount++;
				$display("%s: display shows an illegal digit select or segment pattern", testName);
			end
			else
			begin
				// scan order ones, tens, hundreds
				if ((digitSelect != prevSelect) &&
					(position != (digitPosition(prevSelect) + 1) % 3))
				begin
					errorCount++;
					$display("%s: display digits step out of order", testName);
				end
				shownDigits[position] = shown;
			end

			// a rise on the toggle cycle still belongs to the ending window
			if (peakLed && !prevPeakLed)
			begin
				checkCount++;
				if ((riseCount > 0) && (sinceRise < HoldSamples * FrameBits))
				begin
					errorCount++;
					$display("%s: two peaks only %0d cycles apart", testName, sinceRise);
				end
				if (riseCount >= ArmPeaks)
					windowPeaks++;
				riseCount++;
				sinceRise = 0;
			end

			if (rateLed != prevRateLed)
			begin
				reportCount++;
				checkCount++;
				if (riseCount < ArmPeaks)
				begin
					errorCount++;
					$display("%s: rate reported before arming finished", testName);
				end
				if ((windowPeaks > expectedPeaks + 1) || (windowPeaks < expectedPeaks - 1))
				begin
					errorCount++;
					$display("Mismatch %s peaks per window: expected %0d, actual %0d",
						testName, expectedPeaks, windowPeaks);
				end
				lastRate = windowPeaks * RateScale;
				if (lastRate > 999)
					lastRate = 999;
				windowPeaks = 0;
				scanLeft = 3 * RefreshCycles;
			end

			// the active digit against the last reported rate
			if ((position >= 0) && (shown >= 0))
			begin
				checkCount++;
				wanted = decimalDigit(lastRate, position);
				if (shown != wanted)
				begin
					errorCount++;
					$display("Mismatch %s digit %0d: expected %0d, actual %0d",
						testName, position, wanted, shown);
				end
			end

			// whole displayed value once a full scan has passed
			if (scanLeft > 0)
			begin
				scanLeft--;
				if (scanLeft == 0)
				begin
					checkCount++;
					wanted = shownDigits[2] * 100 + shownDigits[1] * 10 + shownDigits[0];
					if (wanted != lastRate)
					begin
						errorCount++;
						$display("Mismatch %s rate: expected %0d, actual %0d",
							testName, lastRate, wanted);
					end
				end
			end

			if (rowDone)
			begin
				checkCount++;
				if ((expectedPeaks == 0) && ((riseCount != 0) || (reportCount != 0)))
				begin
					errorCount++;
					$display("%s: flat input gave %0d peaks and %0d reports",
						testName, riseCount, reportCount);
				end
				else if ((expectedPeaks != 0) && (reportCount < windows))
				begin
					errorCount++;
					$display("%s: row ended after %0d of %0d reports",
						testName, reportCount, windows);
				end
			end

			prevPeakLed = peakLed;
			prevRateLed = rateLed;
			prevSelect = digitSelect;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/heartMonitor.sv ====
// heart rate monitor top, one clock (sck), frames run back to back from reset
// WindowSamples sets the window length, RefreshCycles the per-digit display time
`default_nettype none

module heartMonitor #(
	parameter int WindowSamples = 2000,
	parameter int RefreshCycles = 250000
) (
	input  logic              sck,
	input  logic              reset,
	input  logic              sdo,
	output logic              peakLed,
	output logic              rateLed,
	output logic [2:0]        digitSelect,
	output heartPkg::segmentsT segments
);
	import heartPkg::*;

	logic   sampleStrobe;
	logic   windowDone;
	logic   windowRun;
	logic   peak;
	sampleT sample;
	sampleT filtered;
	rateT   heartRate;

	// frame timing and window length
	sampleTimer #(.WindowSamples(WindowSamples)) u_timer (
		.sck(sck), .reset(reset), .windowRun(windowRun),
		.sampleStrobe(sampleStrobe), .windowDone(windowDone)
	);

	spiSampler u_sampler (
		.sck(sck), .reset(reset), .sdo(sdo),
		.sampleStrobe(sampleStrobe), .sample(sample)
	);

	firFilter u_filter (
		.sck(sck), .reset(reset), .sampleStrobe(sampleStrobe),
		.sample(sample), .filtered(filtered)
	);

	peakDetector u_detector (
		.sck(sck), .reset(reset), .sampleStrobe(sampleStrobe),
		.filtered(filtered), .peak(peak), .peakLed(peakLed)
	);

	// rateValid has no consumer on the board
	rateControl u_control (
		.sck(sck), .reset(reset), .peak(peak), .windowDone(windowDone),
		.windowRun(windowRun), .heartRate(heartRate), .rateValid(), .rateLed(rateLed)
	);

	rateDisplay #(.RefreshCycles(RefreshCycles)) u_display (
		.sck(sck), .reset(reset), .heartRate(heartRate),
		.digitSelect(digitSelect), .segments(segments)
	);

endmodule

`default_nettype wire

// ==== display/rateDisplay.sv ====
// three-digit decimal display, digit selects and segments active low
// digits scan ones, tens, hundreds, RefreshCycles cycles each
`default_nettype none

module rateDisplay #(
	parameter int RefreshCycles = 250000
) (
	input  logic              sck,
	input  logic              reset,
	input  heartPkg::rateT     heartRate,
	output logic [2:0]        digitSelect,
	output heartPkg::segmentsT segments
);
	import heartPkg::*;

	localparam int DivWidth = (RefreshCycles > 1) ? $clog2(RefreshCycles) : 1;
	localparam logic [DivWidth-1:0] LastCycle = DivWidth'(RefreshCycles - 1);

	logic [11:0] bcd;
	digitT ones;
	digitT tens;
	digitT hundreds;
	digitT shown;
	logic [DivWidth-1:0] refreshCount;
	// one-hot, bit 0 is the ones digit
	logic [2:0] select;

	// shift-and-add-three
	always_comb
	begin
		bcd = '0;
		for (int i = $bits(rateT) - 1; i >= 0; i--)
		begin
			if (bcd[3:0] >= 4'd5)
				bcd[3:0] = bcd[3:0] + 4'd3;
			if (bcd[7:4] >= 4'd5)
				bcd[7:4] = bcd[7:4] + 4'd3;
			if (bcd[11:8] >= 4'd5)
				bcd[11:8] = bcd[11:8] + 4'd3;
			bcd = {bcd[10:0], heartRate[i]};
		end
	end

	assign ones = bcd[3:0];
	assign tens = bcd[7:4];
	assign hundreds = bcd[11:8];

	// refresh divider steps the digit
	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			refreshCount <= '0;
			select <= 3'b001;
		end
		else if (refreshCount == LastCycle)
		begin
			refreshCount <= '0;
			select <= {select[1:0], select[2]};
		end
		else
			refreshCount <= refreshCount + 1'b1;
	end

	assign digitSelect = ~select;

	always_comb
	begin
		case (select)
			3'b010: shown = tens;
			3'b100: shown = hundreds;
			default: shown = ones;
		endcase
	end

	// g-to-a, low lights the segment
	always_comb
	begin
		case (shown)
			4'd0: segments = 7'b100_0000;
			4'd1: segments = 7'b111_1001;
			4'd2: segments = 7'b010_0100;
			4'd3: segments = 7'b011_0000;
			4'd4: segments = 7'b001_1001;
			4'd5: segments = 7'b001_0010;
			4'd6: segments = 7'b000_0010;
			4'd7: segments = 7'b111_1000;
			4'd8: segments = 7'b000_0000;
			4'd9: segments = 7'b001_1000;
			// not a decimal digit, blank
			default: segments = 7'b111_1111;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/rateControl.sv ====
// arm on three peaks, then count peaks per window and report beats per minute
// rate is limited to 999, the peak count saturates at 255
`default_nettype none

module rateControl (
	input  logic          sck,
	input  logic          reset,
	input  logic          peak,
	input  logic          windowDone,
	output logic          windowRun,
	output heartPkg::rateT heartRate,
	output logic          rateValid,
	output logic          rateLed
);
	import heartPkg::*;

	localparam int ProductWidth = $bits(peakCountT) + 3;
	localparam logic [ProductWidth-1:0] MaxRate = ProductWidth'(999);

	rateStateT state;
	peakCountT peakCount;
	peakCountT nextCount;
	logic [ProductWidth-1:0] product;

	// saturating count, includes a peak on the windowDone cycle
	always_comb
	begin
		nextCount = peakCount;
		if (peak && (peakCount != '1))
			nextCount = peakCount + 1'b1;
	end

	assign product = ProductWidth'(nextCount) * ProductWidth'(RateScale);
	assign windowRun = (state == Measuring);

	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			state <= Arming;
			peakCount <= '0;
			heartRate <= '0;
			rateValid <= 1'b0;
			rateLed <= 1'b0;
		end
		else
		begin
			rateValid <= 1'b0;
			case (state)
				Arming:
				begin
					// arming peaks are dropped, count restarts for the first window
					if (peak && (peakCount == peakCountT'(ArmPeaks - 1)))
					begin
						state <= Measuring;
						peakCount <= '0;
					end
					else
						peakCount <= nextCount;
				end
				Measuring:
				begin
					if (windowDone)
					begin
						state <= Reporting;
						heartRate <= (product > MaxRate) ? rateT'(MaxRate) : rateT'(product);
						rateValid <= 1'b1;
						rateLed <= ~rateLed;
						peakCount <= '0;
					end
					else
						peakCount <= nextCount;
				end
				// one cycle with windowRun low, new rate already visible
				Reporting:
					state <= Measuring;
				default:
					state <= Arming;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== peak/peakDetector.sv ====
// peak finder on a 128-bit slope history, flat counts as falling
// after a peak, further peaks are blocked for HoldSamples samples
`default_nettype none

module peakDetector (
	input  logic            sck,
	input  logic            reset,
	input  logic            sampleStrobe,
	input  heartPkg::sampleT filtered,
	output logic            peak,
	output logic            peakLed
);
	import heartPkg::*;

	localparam int HalfLength = HistoryLength / 2;
	localparam int SumWidth = $clog2(HalfLength + 1);
	localparam int HoldWidth = $clog2(HoldSamples + 1);
	localparam logic [SumWidth-1:0] HalfFull = SumWidth'(HalfLength);

	sampleT prevSample;
	logic [HistoryLength-1:0] history;
	// falling bits in the older and newer halves
	logic [SumWidth-1:0] leftSum;
	logic [SumWidth-1:0] rightSum;
	logic [HoldWidth-1:0] holdCount;
	logic falling;
	logic ready;

	assign falling = (filtered <= prevSample);

	// older half mostly rising, newer half mostly falling
	assign ready = (leftSum <= SumWidth'(LeftMax)) &&
		(rightSum >= SumWidth'(RightMin)) && (holdCount == '0);
	assign peak = sampleStrobe && ready;
	assign peakLed = (holdCount != '0);

	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			prevSample <= '0;
			history <= '1;
			leftSum <= HalfFull;
			rightSum <= HalfFull;
			holdCount <= '0;
		end
		else if (sampleStrobe)
		begin
			prevSample <= filtered;
			history <= {history[HistoryLength-2:0], falling};
			// bit crossing the middle leaves the newer half and enters the older
			rightSum <= rightSum + SumWidth'(falling) - SumWidth'(history[HalfLength-1]);
			leftSum <= leftSum + SumWidth'(history[HalfLength-1]) -
				SumWidth'(history[HistoryLength-1]);

			// hold-off
			if (ready)
				holdCount <= HoldWidth'(HoldSamples);
			else if (holdCount != '0)
				holdCount <= holdCount - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== filter/firFilter.sv ====
// 31-tap symmetric FIR, one output per frame, output clamps at full scale
`default_nettype none

module firFilter (
	input  logic            sck,
	input  logic            reset,
	input  logic            sampleStrobe,
	input  heartPkg::sampleT sample,
	output heartPkg::sampleT filtered
);
	import heartPkg::*;

	localparam int PairWidth = $bits(sampleT) + 1;
	localparam int SumWidth = $bits(sampleT) + 11;
	localparam logic [SumWidth-FirShift-1:0] FullScale = {$bits(sampleT){1'b1}};

	// older samples; with the incoming one they form the taps
	sampleT delayLine [FirTaps-1];
	sampleT taps [FirTaps];
	logic [SumWidth-1:0] acc;
	logic [SumWidth-FirShift-1:0] scaled;

	always_comb
	begin
		taps[0] = sample;
		for (int i = 1; i < FirTaps; i++)
			taps[i] = delayLine[i-1];
	end

	// fold mirrored taps before weighting
	always_comb
	begin
		acc = '0;
		for (int i = 0; i < FirHalfTaps; i++)
		begin
			acc = acc + SumWidth'(firCoeffs[i]) *
				SumWidth'(PairWidth'(taps[i]) + PairWidth'(taps[FirTaps-1-i]));
		end
		// centre tap, largest weight
		acc = acc + SumWidth'(firCoeffs[FirHalfTaps]) * SumWidth'(taps[FirHalfTaps]);
	end

	assign scaled = acc[SumWidth-1:FirShift];

	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < FirTaps - 1; i++)
				delayLine[i] <= '0;
			filtered <= '0;
		end
		else if (sampleStrobe)
		begin
			for (int i = 0; i < FirTaps - 1; i++)
				delayLine[i] <= taps[i];
			// coefficients add up to slightly over 1024
			if (scaled > FullScale)
				filtered <= '1;
			else
				filtered <= sampleT'(scaled);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sampleTimer.sv ====
// frame bit counter and window sample counter
// windowDone fires on the strobe that completes WindowSamples samples
`default_nettype none

module sampleTimer #(
	parameter int WindowSamples = 2000
) (
	input  logic sck,
	input  logic reset,
	input  logic windowRun,
	output logic sampleStrobe,
	output logic windowDone
);
	import heartPkg::*;

	localparam int BitWidth = $clog2(FrameBits);
	localparam logic [BitWidth-1:0] LastBit = BitWidth'(FrameBits - 1);
	localparam int CountWidth = (WindowSamples > 1) ? $clog2(WindowSamples) : 1;
	localparam logic [CountWidth-1:0] LastSample = CountWidth'(WindowSamples - 1);

	logic [BitWidth-1:0]   bitCount;
	logic [CountWidth-1:0] windowCount;

	// last bit of the frame
	assign sampleStrobe = (bitCount == LastBit);
	assign windowDone = windowRun && sampleStrobe && (windowCount == LastSample);

	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			bitCount <= '0;
			windowCount <= '0;
		end
		else
		begin
			// wraps every frame
			if (sampleStrobe)
				bitCount <= '0;
			else
				bitCount <= bitCount + 1'b1;

			// held at zero outside a window
			if (!windowRun || windowDone)
				windowCount <= '0;
			else if (sampleStrobe)
				windowCount <= windowCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spiSampler.sv ====
// serial sample capture, MSB first, only the low 10 bits of a frame are kept
`default_nettype none

module spiSampler (
	input  logic            sck,
	input  logic            reset,
	input  logic            sdo,
	input  logic            sampleStrobe,
	output heartPkg::sampleT sample
);
	import heartPkg::*;

	// older frame bits simply fall off the top
	logic [$bits(sampleT)-2:0] shiftReg;

	always_ff @(posedge sck)
	begin
		shiftReg <= {shiftReg[$bits(sampleT)-3:0], sdo};
	end

	// strobe cycle carries the last bit, so take it straight from sdo
	always_ff @(posedge sck or posedge reset)
	begin
		if (reset)
			sample <= '0;
		else if (sampleStrobe)
			sample <= {shiftReg, sdo};
	end

endmodule

`default_nettype wire

// ==== common/heartPkg.sv ====
// shared widths, FIR coefficients and detector thresholds
// coefficients are scaled by 1024, so the filter gain is close to one
`default_nettype none

package heartPkg;

	// serial frame and sample widths
	localparam int FrameBits = 16;
	typedef logic [9:0] sampleT;
	typedef logic [9:0] rateT;
	typedef logic [7:0] peakCountT;
	typedef logic [3:0] digitT;
	// active low, g down to a
	typedef logic [6:0] segmentsT;

	// 31-tap symmetric low-pass, outer tap first, centre tap last
	localparam int FirHalfTaps = 15;
	localparam int FirTaps = 2 * FirHalfTaps + 1;
	localparam int FirShift = 10;
	localparam int unsigned firCoeffs [FirHalfTaps + 1] = '{
		3, 4, 6, 8, 12, 17, 23, 29, 36, 43, 50, 56, 61, 65, 67, 68
	};

	// slope history and peak rule
	localparam int HistoryLength = 128;
	localparam int LeftMax = 40;
	localparam int RightMin = 38;
	localparam int HoldSamples = 128;

	// rate controller
	localparam int ArmPeaks = 3;
	// one minute over the window length
	localparam int RateScale = 6;
	typedef enum logic [1:0] {Arming, Measuring, Reporting} rateStateT;

endpackage

`default_nettype wire
